/* hw/dispatch_pkg.sv */
package dispatch_pkg;

	localparam int WORD_W = 32;
	localparam int REG_IDX_W = 5;
	localparam int GR_COUNT = 32;
	localparam int CMD_W = 5;
	localparam int CC_W = 4;

	// One-hot unit select with the branch unit in the MSB
	localparam int EX_UNIT_W = 10;

	// System register indices
	localparam logic [REG_IDX_W-1:0] SYSREG_CPUIDR = 5'd0;
	localparam logic [REG_IDX_W-1:0] SYSREG_COREIDR = 5'd1;
	localparam logic [REG_IDX_W-1:0] SYSREG_TIDR = 5'd2;
	localparam logic [REG_IDX_W-1:0] SYSREG_PCR = 5'd4;
	localparam logic [REG_IDX_W-1:0] SYSREG_SPR = 5'd5;
	localparam logic [REG_IDX_W-1:0] SYSREG_PSR = 5'd6;
	localparam logic [REG_IDX_W-1:0] SYSREG_IDTR = 5'd7;
	localparam logic [REG_IDX_W-1:0] SYSREG_PPSR = 5'd12;
	localparam logic [REG_IDX_W-1:0] SYSREG_PPCR = 5'd13;
	localparam logic [REG_IDX_W-1:0] SYSREG_PTIDR = 5'd15;

	// CPUIDR halves
	localparam logic [15:0] PROCESSOR_ID = 16'h5a31;
	localparam logic [15:0] PROCESSOR_REVISION = 16'h0003;

	// Source 1 word as an immediate or as a register pointer
	typedef union packed {
		logic [WORD_W-1:0] imm;
		struct packed {
			logic [WORD_W-REG_IDX_W-1:0] pad;
			logic [REG_IDX_W-1:0] ptr;
		} reg_ref;
	} src1_word_u;

endpackage

/* hw/dispatch_wb_if.sv */
`timescale 1ns/1ps

interface wb_bus_if import dispatch_pkg::*; ();
	logic valid;
	logic commit;
	logic [WORD_W-1:0] data;
	logic [REG_IDX_W-1:0] destination;
	logic destination_sysreg;
	logic writeback;
	logic spr_writeback;
	logic [WORD_W-1:0] spr;
	logic [WORD_W-1:0] pc;
	logic branch;
	logic [WORD_W-1:0] branch_pc;

	modport src (output valid, commit, data, destination, destination_sysreg, writeback,
		spr_writeback, spr, pc, branch, branch_pc);
	modport gr (input commit, data, destination, destination_sysreg, writeback);
	modport sys (input commit, data, destination, destination_sysreg, writeback,
		spr_writeback, spr, pc, branch, branch_pc);
	// Forwarding looks at valid, not commit
	modport fwd (input valid, data, destination, destination_sysreg, writeback,
		spr_writeback, spr, pc);
endinterface

interface sysreg_rd_if import dispatch_pkg::*; ();
	logic active0;
	logic active1;
	logic [REG_IDX_W-1:0] idx0;
	logic [REG_IDX_W-1:0] idx1;
	logic [WORD_W-1:0] pc;
	logic hit0;
	logic hit1;
	logic [WORD_W-1:0] val0;
	logic [WORD_W-1:0] val1;

	modport req (output active0, active1, idx0, idx1, pc, input hit0, hit1, val0, val1);
	modport rsp (input active0, active1, idx0, idx1, pc, output hit0, hit1, val0, val1);
endinterface

/* hw/gr_file.sv */
`timescale 1ns/1ps

module gr_file import dispatch_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	wb_bus_if.gr wb,
	input logic [REG_IDX_W-1:0] rd_idx0,
	input logic [REG_IDX_W-1:0] rd_idx1,
	output logic [WORD_W-1:0] rd_val0,
	output logic [WORD_W-1:0] rd_val1
);

	logic [WORD_W-1:0] regs [GR_COUNT];
	logic wr_en;

	assign wr_en = wb.commit && !wb.destination_sysreg && wb.writeback;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < GR_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wb.destination] <= wb.data;
		end
	end

	// Asynchronous reads with the bypass left to operand_select
	assign rd_val0 = regs[rd_idx0];
	assign rd_val1 = regs[rd_idx1];

endmodule

/* hw/sysreg_file.sv */
`timescale 1ns/1ps

module sysreg_file import dispatch_pkg::*; #(
	parameter int CORE_ID = 0
) (
	input logic iCLOCK,
	input logic inRESET,
	input logic refresh,
	input logic irq_set,
	input logic irq_clr,
	input logic ppcr_set,
	input logic [WORD_W-1:0] ppcr,
	wb_bus_if.sys wb,
	sysreg_rd_if.rsp rd,
	output logic pcr_valid,
	output logic [WORD_W-1:0] pcr,
	output logic [WORD_W-1:0] spr,
	output logic [WORD_W-1:0] psr,
	output logic [WORD_W-1:0] ppsr,
	output logic [WORD_W-1:0] ppcr_q,
	output logic [WORD_W-1:0] tidr,
	output logic [WORD_W-1:0] idtr
);

	localparam logic [WORD_W-1:0] CPUIDR_VAL = {PROCESSOR_ID, PROCESSOR_REVISION};
	localparam logic [WORD_W-1:0] COREIDR_VAL = WORD_W'(CORE_ID);
	// PSR bits 6, 5 and 2 are masked on interrupt entry
	localparam logic [WORD_W-1:0] PSR_IRQ_MASK = 32'h0000_0064;

	logic [WORD_W-1:0] ptidr;
	logic sys_wr;

	assign sys_wr = wb.commit && wb.destination_sysreg && wb.writeback;

	function automatic logic wr_to(input logic [REG_IDX_W-1:0] idx);
		return sys_wr && (wb.destination == idx);
	endfunction

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			pcr <= '0;
			spr <= '0;
			psr <= '0;
			ppsr <= '0;
			tidr <= '0;
			ptidr <= '0;
			idtr <= '0;
			ppcr_q <= '0;
		end else begin
			if (wb.commit) begin
				pcr <= wb.branch ? wb.branch_pc : wb.pc;
			end
			if (wb.commit && wb.spr_writeback) begin
				spr <= wb.spr;
			end else if (wr_to(SYSREG_SPR)) begin
				spr <= wb.data;
			end
			// Interrupt entry and return win over write-back
			if (irq_set) begin
				psr <= psr & ~PSR_IRQ_MASK;
			end else if (irq_clr) begin
				psr <= ppsr;
			end else if (wr_to(SYSREG_PSR)) begin
				psr <= wb.data;
			end
			if (irq_set) begin
				ppsr <= psr;
			end else if (wr_to(SYSREG_PPSR)) begin
				ppsr <= wb.data;
			end
			if (wr_to(SYSREG_TIDR)) begin
				tidr <= wb.data;
			end
			if (irq_set) begin
				ptidr <= tidr;
			end else if (wr_to(SYSREG_PTIDR)) begin
				ptidr <= wb.data;
			end
			if (wr_to(SYSREG_IDTR)) begin
				idtr <= wb.data;
			end
			if (ppcr_set) begin
				ppcr_q <= ppcr;
			end else if (wr_to(SYSREG_PPCR)) begin
				ppcr_q <= wb.data;
			end
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			pcr_valid <= 1'b0;
		end else if (refresh) begin
			pcr_valid <= 1'b0;
		end else if (wb.commit) begin
			pcr_valid <= 1'b1;
		end
	end

	function automatic logic [WORD_W:0] read_sel(input logic active,
		input logic [REG_IDX_W-1:0] idx);
		logic [WORD_W-1:0] val;
		logic hit;
		hit = active;
		case (idx)
			SYSREG_CPUIDR: val = CPUIDR_VAL;
			SYSREG_COREIDR: val = COREIDR_VAL;
			SYSREG_TIDR: val = tidr;
			// PC of the instruction being dispatched minus one word
			SYSREG_PCR: val = rd.pc - WORD_W'(4);
			SYSREG_SPR: val = spr;
			SYSREG_PSR: val = psr;
			SYSREG_IDTR: val = idtr;
			SYSREG_PPSR: val = ppsr;
			SYSREG_PPCR: val = ppcr_q;
			SYSREG_PTIDR: val = ptidr;
			default: begin
				hit = 1'b0;
				val = '0;
			end
		endcase
		return {hit, val};
	endfunction

	always_comb begin
		{rd.hit0, rd.val0} = read_sel(rd.active0, rd.idx0);
		{rd.hit1, rd.val1} = read_sel(rd.active1, rd.idx1);
	end

endmodule

/* hw/operand_select.sv */
`timescale 1ns/1ps

module operand_select import dispatch_pkg::*; (
	wb_bus_if.fwd wb,
	sysreg_rd_if.req sr,
	input logic src0_active,
	input logic src1_active,
	input logic src0_sysreg,
	input logic src1_sysreg,
	input logic src1_imm,
	input logic [REG_IDX_W-1:0] src0,
	input src1_word_u src1,
	input logic [WORD_W-1:0] pc,
	output logic [REG_IDX_W-1:0] gr_idx0,
	output logic [REG_IDX_W-1:0] gr_idx1,
	input logic [WORD_W-1:0] gr_val0,
	input logic [WORD_W-1:0] gr_val1,
	output logic [WORD_W-1:0] operand0,
	output logic [WORD_W-1:0] operand1
);

	logic fwd_hit0;
	logic fwd_hit1;
	logic [WORD_W-1:0] fwd_val0;
	logic [WORD_W-1:0] fwd_val1;
	logic [REG_IDX_W-1:0] src1_ptr;

	assign src1_ptr = src1.reg_ref.ptr;

	assign gr_idx0 = src0;
	assign gr_idx1 = src1_ptr;

	assign sr.active0 = src0_active;
	assign sr.active1 = src1_active;
	assign sr.idx0 = src0;
	assign sr.idx1 = src1_ptr;
	assign sr.pc = pc;

	// Bypass of the write-back seen in this cycle
	function automatic logic [WORD_W:0] forward(input logic [REG_IDX_W-1:0] idx,
		input logic sysreg);
		logic [WORD_W:0] res;
		res = '0;
		if (wb.valid && sysreg && wb.destination_sysreg) begin
			if (idx == SYSREG_PCR) begin
				res = {1'b1, wb.pc};
			end else if (idx == SYSREG_SPR && wb.spr_writeback) begin
				res = {1'b1, wb.spr};
			end else if (idx == wb.destination && wb.writeback) begin
				res = {1'b1, wb.data};
			end
		end else if (wb.valid && !sysreg) begin
			if (idx == wb.destination && !wb.destination_sysreg && wb.writeback) begin
				res = {1'b1, wb.data};
			end
		end
		return res;
	endfunction

	always_comb begin
		{fwd_hit0, fwd_val0} = forward(src0, src0_sysreg);
		{fwd_hit1, fwd_val1} = forward(src1_ptr, src1_sysreg);
	end

	always_comb begin
		if (fwd_hit0) begin
			operand0 = fwd_val0;
		end else if (src0_sysreg && sr.hit0) begin
			operand0 = sr.val0;
		end else begin
			operand0 = gr_val0;
		end
	end

	// Immediate first, then bypass, then register files
	always_comb begin
		if (src1_imm) begin
			operand1 = src1.imm;
		end else if (fwd_hit1) begin
			operand1 = fwd_val1;
		end else if (src1_sysreg && sr.hit1) begin
			operand1 = sr.val1;
		end else begin
			operand1 = gr_val1;
		end
	end

endmodule

/* hw/dispatch_latch.sv */
`timescale 1ns/1ps

module dispatch_latch import dispatch_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	input logic refresh,
	input logic next_lock,
	input logic pcr_valid,
	input logic previous_valid,
	input logic [WORD_W-1:0] operand0,
	input logic [WORD_W-1:0] operand1,
	input logic [REG_IDX_W-1:0] src0_ptr,
	input logic [REG_IDX_W-1:0] src1_ptr,
	input logic src0_sysreg,
	input logic src1_sysreg,
	input logic src1_imm,
	input logic dest_sysreg,
	input logic [REG_IDX_W-1:0] dest,
	input logic writeback,
	input logic flags_writeback,
	input logic [CMD_W-1:0] cmd,
	input logic [CC_W-1:0] cc,
	input logic [EX_UNIT_W-1:0] ex_unit,
	input logic [WORD_W-1:0] pc,
	output logic next_valid,
	output logic [WORD_W-1:0] next_src0,
	output logic [WORD_W-1:0] next_src1,
	output logic [REG_IDX_W-1:0] next_src0_ptr,
	output logic [REG_IDX_W-1:0] next_src1_ptr,
	output logic next_src0_sysreg,
	output logic next_src1_sysreg,
	output logic next_src1_imm,
	output logic next_dest_sysreg,
	output logic [REG_IDX_W-1:0] next_dest,
	output logic next_writeback,
	output logic next_flags_writeback,
	output logic [CMD_W-1:0] next_cmd,
	output logic [CC_W-1:0] next_cc,
	output logic [EX_UNIT_W-1:0] next_ex_unit,
	output logic [WORD_W-1:0] next_pc,
	output logic exception_lock
);

	logic valid_q;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid_q <= 1'b0;
		end else if (refresh) begin
			valid_q <= 1'b0;
		end else if (!next_lock) begin
			valid_q <= previous_valid;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (refresh) begin
			{next_src0, next_src1, next_src0_ptr, next_src1_ptr} <= '0;
			{next_src0_sysreg, next_src1_sysreg, next_src1_imm} <= '0;
			{next_dest_sysreg, next_dest, next_writeback, next_flags_writeback} <= '0;
			{next_cmd, next_cc, next_ex_unit, next_pc} <= '0;
		end else if (!next_lock) begin
			next_src0 <= operand0;
			next_src1 <= operand1;
			next_src0_ptr <= src0_ptr;
			next_src1_ptr <= src1_ptr;
			next_src0_sysreg <= src0_sysreg;
			next_src1_sysreg <= src1_sysreg;
			next_src1_imm <= src1_imm;
			next_dest_sysreg <= dest_sysreg;
			next_dest <= dest;
			next_writeback <= writeback;
			next_flags_writeback <= flags_writeback;
			next_cmd <= cmd;
			next_cc <= cc;
			next_ex_unit <= ex_unit;
			next_pc <= pc;
		end
	end

	assign next_valid = valid_q && !next_lock;

	// Top bit of the unit select is the branch unit
	assign exception_lock = !pcr_valid || !valid_q || next_ex_unit[EX_UNIT_W-1];

endmodule

/* hw/dispatch_top.sv */
`timescale 1ns/1ps

module dispatch_top import dispatch_pkg::*; #(
	parameter int CORE_ID = 0
) (
	input logic iCLOCK,
	input logic inRESET,
	input logic pipeline_stop,
	input logic refresh,
	input logic irq_set,
	input logic irq_clr,
	input logic ppcr_set,
	input logic [WORD_W-1:0] ppcr,
	input logic previous_valid,
	input logic previous_src0_active,
	input logic previous_src1_active,
	input logic previous_src0_sysreg,
	input logic previous_src1_sysreg,
	input logic previous_src1_imm,
	input logic [REG_IDX_W-1:0] previous_src0,
	input logic [WORD_W-1:0] previous_src1,
	input logic previous_dest_sysreg,
	input logic [REG_IDX_W-1:0] previous_dest,
	input logic previous_writeback,
	input logic previous_flags_writeback,
	input logic [CMD_W-1:0] previous_cmd,
	input logic [CC_W-1:0] previous_cc,
	input logic [EX_UNIT_W-1:0] previous_ex_unit,
	input logic [WORD_W-1:0] previous_pc,
	input logic next_lock,
	input logic wb_valid,
	input logic [WORD_W-1:0] wb_data,
	input logic [REG_IDX_W-1:0] wb_dest,
	input logic wb_dest_sysreg,
	input logic wb_writeback,
	input logic wb_spr_writeback,
	input logic [WORD_W-1:0] wb_spr,
	input logic [WORD_W-1:0] wb_pc,
	input logic wb_branch,
	input logic [WORD_W-1:0] wb_branch_pc,
	output logic previous_lock,
	output logic exception_lock,
	output logic next_valid,
	output logic [WORD_W-1:0] next_src0,
	output logic [WORD_W-1:0] next_src1,
	output logic [REG_IDX_W-1:0] next_src0_ptr,
	output logic [REG_IDX_W-1:0] next_src1_ptr,
	output logic next_src0_sysreg,
	output logic next_src1_sysreg,
	output logic next_src1_imm,
	output logic next_dest_sysreg,
	output logic [REG_IDX_W-1:0] next_dest,
	output logic next_writeback,
	output logic next_flags_writeback,
	output logic [CMD_W-1:0] next_cmd,
	output logic [CC_W-1:0] next_cc,
	output logic [EX_UNIT_W-1:0] next_ex_unit,
	output logic [WORD_W-1:0] next_pc,
	output logic [WORD_W-1:0] sysreg_pcr,
	output logic [WORD_W-1:0] sysreg_spr,
	output logic [WORD_W-1:0] sysreg_psr,
	output logic [WORD_W-1:0] sysreg_ppsr,
	output logic [WORD_W-1:0] sysreg_ppcr,
	output logic [WORD_W-1:0] sysreg_tidr,
	output logic [WORD_W-1:0] sysreg_idtr
);

	wb_bus_if wb ();
	sysreg_rd_if srd ();

	src1_word_u src1_word;
	logic [REG_IDX_W-1:0] gr_idx0;
	logic [REG_IDX_W-1:0] gr_idx1;
	logic [WORD_W-1:0] gr_val0;
	logic [WORD_W-1:0] gr_val1;
	logic [WORD_W-1:0] operand0;
	logic [WORD_W-1:0] operand1;
	logic pcr_valid;

	assign wb.valid = wb_valid;
	// A stalled pipeline sees the write-back but does not retire it
	assign wb.commit = wb_valid && !pipeline_stop;
	assign wb.data = wb_data;
	assign wb.destination = wb_dest;
	assign wb.destination_sysreg = wb_dest_sysreg;
	assign wb.writeback = wb_writeback;
	assign wb.spr_writeback = wb_spr_writeback;
	assign wb.spr = wb_spr;
	assign wb.pc = wb_pc;
	assign wb.branch = wb_branch;
	assign wb.branch_pc = wb_branch_pc;

	assign src1_word = previous_src1;
	assign previous_lock = next_lock;

	gr_file u_gr_file (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .wb(wb.gr),
		.rd_idx0(gr_idx0), .rd_idx1(gr_idx1), .rd_val0(gr_val0), .rd_val1(gr_val1)
	);

	sysreg_file #(.CORE_ID(CORE_ID)) u_sysreg_file (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .refresh(refresh),
		.irq_set(irq_set), .irq_clr(irq_clr), .ppcr_set(ppcr_set), .ppcr(ppcr),
		.wb(wb.sys), .rd(srd.rsp), .pcr_valid(pcr_valid),
		.pcr(sysreg_pcr), .spr(sysreg_spr), .psr(sysreg_psr), .ppsr(sysreg_ppsr),
		.ppcr_q(sysreg_ppcr), .tidr(sysreg_tidr), .idtr(sysreg_idtr)
	);

	operand_select u_operand_select (
		.wb(wb.fwd), .sr(srd.req),
		.src0_active(previous_src0_active), .src1_active(previous_src1_active),
		.src0_sysreg(previous_src0_sysreg), .src1_sysreg(previous_src1_sysreg),
		.src1_imm(previous_src1_imm), .src0(previous_src0), .src1(src1_word),
		.pc(previous_pc), .gr_idx0(gr_idx0), .gr_idx1(gr_idx1),
		.gr_val0(gr_val0), .gr_val1(gr_val1), .operand0(operand0), .operand1(operand1)
	);

	dispatch_latch u_dispatch_latch (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .refresh(refresh), .next_lock(next_lock),
		.pcr_valid(pcr_valid), .previous_valid(previous_valid),
		.operand0(operand0), .operand1(operand1),
		.src0_ptr(previous_src0), .src1_ptr(src1_word.reg_ref.ptr),
		.src0_sysreg(previous_src0_sysreg), .src1_sysreg(previous_src1_sysreg),
		.src1_imm(previous_src1_imm), .dest_sysreg(previous_dest_sysreg),
		.dest(previous_dest), .writeback(previous_writeback),
		.flags_writeback(previous_flags_writeback), .cmd(previous_cmd),
		.cc(previous_cc), .ex_unit(previous_ex_unit), .pc(previous_pc),
		.next_valid(next_valid), .next_src0(next_src0), .next_src1(next_src1),
		.next_src0_ptr(next_src0_ptr), .next_src1_ptr(next_src1_ptr),
		.next_src0_sysreg(next_src0_sysreg), .next_src1_sysreg(next_src1_sysreg),
		.next_src1_imm(next_src1_imm), .next_dest_sysreg(next_dest_sysreg),
		.next_dest(next_dest), .next_writeback(next_writeback),
		.next_flags_writeback(next_flags_writeback), .next_cmd(next_cmd),
		.next_cc(next_cc), .next_ex_unit(next_ex_unit), .next_pc(next_pc),
		.exception_lock(exception_lock)
	);

endmodule

/* dv/tb_dispatch_tasks.svh */
`ifndef TB_DISPATCH_TASKS_SVH
`define TB_DISPATCH_TASKS_SVH

// PSR bits 6, 5 and 2
localparam logic [WORD_W-1:0] PSR_IRQ_BITS = (32'd1 << 6) | (32'd1 << 5) | (32'd1 << 2);

logic [15:0] lfsr_state = 16'd76;

// Reference model of the registers
logic [WORD_W-1:0] model_gr [GR_COUNT] = '{default: '0};
logic [WORD_W-1:0] model_pcr = '0;
logic [WORD_W-1:0] model_spr = '0;
logic [WORD_W-1:0] model_psr = '0;
logic [WORD_W-1:0] model_ppsr = '0;
logic [WORD_W-1:0] model_tidr = '0;
logic [WORD_W-1:0] model_ptidr = '0;
logic [WORD_W-1:0] model_idtr = '0;
logic [WORD_W-1:0] model_ppcr = '0;

// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic lfsr_bit();
	logic fb;
	fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
	lfsr_state = {lfsr_state[14:0], fb};
	return fb;
endfunction

function automatic logic [WORD_W-1:0] rand_bits(input int n);
	logic [WORD_W-1:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		v = {v[WORD_W-2:0], lfsr_bit()};
	end
	return v;
endfunction

// Word aligned
function automatic logic [WORD_W-1:0] rand_pc();
	logic [WORD_W-1:0] v;
	v = rand_bits(30);
	return {v[29:0], 2'b00};
endfunction

task automatic idle_inputs();
	{pipeline_stop, refresh, irq_set, irq_clr, ppcr_set, next_lock} = '0;
	ppcr = '0;
	{previous_valid, previous_src0_active, previous_src1_active} = '0;
	{previous_src0_sysreg, previous_src1_sysreg, previous_src1_imm} = '0;
	{previous_src0, previous_src1, previous_pc} = '0;
	{previous_dest_sysreg, previous_dest, previous_writeback, previous_flags_writeback} = '0;
	{previous_cmd, previous_cc, previous_ex_unit} = '0;
	{wb_valid, wb_dest_sysreg, wb_dest, wb_writeback, wb_spr_writeback, wb_branch} = '0;
	{wb_data, wb_spr, wb_pc, wb_branch_pc} = '0;
endtask

// One committed write-back strobe mirrored in the model
task automatic drive_wb(input logic sys, input logic [REG_IDX_W-1:0] dest,
	input logic [WORD_W-1:0] data, input logic br);
	wb_valid = 1'b1;
	wb_writeback = 1'b1;
	wb_dest_sysreg = sys;
	wb_dest = dest;
	wb_data = data;
	wb_branch = br;
	wb_pc = rand_pc();
	wb_branch_pc = rand_pc();
	model_pcr = br ? wb_branch_pc : wb_pc;
	if (!sys) begin
		model_gr[dest] = data;
	end else begin
		case (dest)
			SYSREG_SPR: model_spr = data;
			SYSREG_PSR: model_psr = data;
			SYSREG_TIDR: model_tidr = data;
			SYSREG_IDTR: model_idtr = data;
			SYSREG_PPSR: model_ppsr = data;
			SYSREG_PPCR: model_ppcr = data;
			SYSREG_PTIDR: model_ptidr = data;
			default: ;
		endcase
	end
endtask

task automatic drive_instr(input logic s0_sys, input logic [REG_IDX_W-1:0] s0,
	input logic s1_sys, input logic s1_imm, input logic [WORD_W-1:0] s1,
	input logic [WORD_W-1:0] pc, input logic [EX_UNIT_W-1:0] unit);
	previous_valid = 1'b1;
	previous_src0_active = 1'b1;
	previous_src1_active = 1'b1;
	previous_src0_sysreg = s0_sys;
	previous_src0 = s0;
	previous_src1_sysreg = s1_sys;
	previous_src1_imm = s1_imm;
	previous_src1 = s1;
	previous_pc = pc;
	previous_ex_unit = unit;
	previous_writeback = lfsr_bit();
	previous_flags_writeback = lfsr_bit();
	previous_dest_sysreg = lfsr_bit();
	previous_dest = REG_IDX_W'(rand_bits(REG_IDX_W));
	previous_cmd = CMD_W'(rand_bits(CMD_W));
	previous_cc = CC_W'(rand_bits(CC_W));
endtask

`endif

/* dv/tb_dispatch.sv */
`timescale 1ns/1ps

module tb_dispatch import dispatch_pkg::*; ();

	localparam int CORE_ID_TB = 3;
	localparam int RESET_CYCLES = 16;
	localparam int N_GR_WB = 40;
	localparam int N_GR_RD = 24;
	localparam int N_LOCK_HOLD = 4;
	// Directed sections rounded up
	localparam int N_DIRECTED = 32;
	localparam int RUN_CYCLES = RESET_CYCLES + N_GR_WB + N_GR_RD + N_LOCK_HOLD + N_DIRECTED;
	localparam int FIELDS_W = 3 * REG_IDX_W + 6 + CMD_W + CC_W + EX_UNIT_W + WORD_W;
	localparam logic [EX_UNIT_W-1:0] UNIT_SYSREG = 10'h001;
	localparam logic [EX_UNIT_W-1:0] UNIT_LOGIC = 10'h004;
	localparam logic [EX_UNIT_W-1:0] UNIT_BRANCH = 10'h200;

	logic iCLOCK;
	logic inRESET;
	logic pipeline_stop, refresh, irq_set, irq_clr, ppcr_set;
	logic [WORD_W-1:0] ppcr;
	logic previous_valid, previous_src0_active, previous_src1_active;
	logic previous_src0_sysreg, previous_src1_sysreg, previous_src1_imm;
	logic [REG_IDX_W-1:0] previous_src0;
	logic [WORD_W-1:0] previous_src1;
	logic previous_dest_sysreg, previous_writeback, previous_flags_writeback;
	logic [REG_IDX_W-1:0] previous_dest;
	logic [CMD_W-1:0] previous_cmd;
	logic [CC_W-1:0] previous_cc;
	logic [EX_UNIT_W-1:0] previous_ex_unit;
	logic [WORD_W-1:0] previous_pc;
	logic next_lock;
	logic wb_valid, wb_dest_sysreg, wb_writeback, wb_spr_writeback, wb_branch;
	logic [WORD_W-1:0] wb_data, wb_spr, wb_pc, wb_branch_pc;
	logic [REG_IDX_W-1:0] wb_dest;
	logic previous_lock, exception_lock, next_valid;
	logic next_src0_sysreg, next_src1_sysreg, next_src1_imm, next_dest_sysreg;
	logic next_writeback, next_flags_writeback;
	logic [WORD_W-1:0] next_src0, next_src1, next_pc;
	logic [REG_IDX_W-1:0] next_src0_ptr, next_src1_ptr, next_dest;
	logic [CMD_W-1:0] next_cmd;
	logic [CC_W-1:0] next_cc;
	logic [EX_UNIT_W-1:0] next_ex_unit;
	logic [WORD_W-1:0] sysreg_pcr, sysreg_spr, sysreg_psr, sysreg_ppsr;
	logic [WORD_W-1:0] sysreg_ppcr, sysreg_tidr, sysreg_idtr;

	dispatch_top #(.CORE_ID(CORE_ID_TB)) dut0 (.*);

	`include "tb_dispatch_tasks.svh"

	task automatic fail_check(input string msg);
		$display("FAIL %0t ns: %s", $time, msg);
		$display("TEST FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(input logic [WORD_W-1:0] got, input logic [WORD_W-1:0] exp,
		input string what);
		assert (got === exp) else begin
			fail_check($sformatf("%s is %h, expected %h", what, got, exp));
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		assert (got === exp) else begin
			fail_check($sformatf("%s is %b, expected %b", what, got, exp));
		end
	endtask

	// Pass-through fields in output port order
	function automatic logic [FIELDS_W-1:0] driven_fields();
		return {previous_src0, previous_src1[REG_IDX_W-1:0], previous_src0_sysreg,
			previous_src1_sysreg, previous_src1_imm, previous_dest_sysreg, previous_dest,
			previous_writeback, previous_flags_writeback, previous_cmd, previous_cc,
			previous_ex_unit, previous_pc};
	endfunction

	task automatic check_fields(input logic [FIELDS_W-1:0] exp, input string what);
		logic [FIELDS_W-1:0] got;
		got = {next_src0_ptr, next_src1_ptr, next_src0_sysreg, next_src1_sysreg,
			next_src1_imm, next_dest_sysreg, next_dest, next_writeback,
			next_flags_writeback, next_cmd, next_cc, next_ex_unit, next_pc};
		assert (got === exp) else begin
			fail_check($sformatf("%s fields are %h, expected %h", what, got, exp));
		end
	endtask

	initial begin
		iCLOCK = 1'b0;
		forever #5 iCLOCK = ~iCLOCK;
	end

	initial begin
		repeat (RUN_CYCLES + 200) @(posedge iCLOCK);
		$display("Watchdog expired after %0d cycles, the run hung", RUN_CYCLES + 200);
		$display("TEST FAILED");
		$fatal(1, "timeout");
	end

	initial begin
		logic [REG_IDX_W-1:0] idx0;
		logic [WORD_W-1:0] word1;
		logic [WORD_W-1:0] exp0;
		logic [WORD_W-1:0] exp1;
		logic [WORD_W-1:0] pc_a;
		logic [WORD_W-1:0] pc_b;
		logic [FIELDS_W-1:0] exp_fields;
		idle_inputs();
		inRESET = 1'b0;
		repeat (RESET_CYCLES) @(negedge iCLOCK);
		inRESET = 1'b1;
		check_bit(next_valid, 1'b0, "next_valid after reset");
		check_bit(exception_lock, 1'b1, "exception_lock after reset");

		for (int i = 0; i < N_GR_WB; i++) begin
			idle_inputs();
			drive_wb(1'b0, REG_IDX_W'(rand_bits(REG_IDX_W)), rand_bits(WORD_W), 1'b0);
			@(negedge iCLOCK);
		end

		// Reads where some hit a write-back in the same cycle
		for (int i = 0; i < N_GR_RD; i++) begin
			idx0 = REG_IDX_W'(rand_bits(REG_IDX_W));
			word1 = rand_bits(WORD_W);
			pc_a = rand_pc();
			idle_inputs();
			if (i % 3 == 1) begin
				drive_wb(1'b0, idx0, rand_bits(WORD_W), 1'b0);
			end else if (i % 3 == 2) begin
				drive_wb(1'b0, word1[REG_IDX_W-1:0], rand_bits(WORD_W), 1'b0);
			end
			drive_instr(1'b0, idx0, 1'b0, 1'b0, word1, pc_a, UNIT_LOGIC);
			// Model already holds the forwarded data
			exp0 = model_gr[idx0];
			exp1 = model_gr[word1[REG_IDX_W-1:0]];
			exp_fields = driven_fields();
			@(negedge iCLOCK);
			check_bit(next_valid, 1'b1, "next_valid");
			check_bit(exception_lock, 1'b0, "exception_lock on non-branch");
			check_word(next_src0, exp0, "GR operand 0");
			check_word(next_src1, exp1, "GR operand 1");
			check_fields(exp_fields, "GR read");
		end

		idle_inputs();
		word1 = rand_bits(WORD_W);
		drive_instr(1'b0, 5'd1, 1'b0, 1'b1, word1, rand_pc(), UNIT_LOGIC);
		exp_fields = driven_fields();
		@(negedge iCLOCK);
		check_word(next_src1, word1, "immediate operand");
		check_fields(exp_fields, "immediate");

		idle_inputs();
		drive_wb(1'b1, SYSREG_SPR, rand_bits(WORD_W), 1'b0);
		@(negedge iCLOCK);
		check_word(sysreg_spr, model_spr, "SPR write-back");
		idle_inputs();
		drive_wb(1'b1, SYSREG_IDTR, rand_bits(WORD_W), 1'b0);
		@(negedge iCLOCK);
		check_word(sysreg_idtr, model_idtr, "IDTR write-back");
		idle_inputs();
		drive_wb(1'b1, SYSREG_TIDR, rand_bits(WORD_W), 1'b0);
		@(negedge iCLOCK);
		check_word(sysreg_tidr, model_tidr, "TIDR write-back");
		// Masked bits set so the interrupt swap shows
		idle_inputs();
		drive_wb(1'b1, SYSREG_PSR, rand_bits(WORD_W) | PSR_IRQ_BITS, 1'b0);
		@(negedge iCLOCK);
		check_word(sysreg_psr, model_psr, "PSR write-back");

		idle_inputs();
		pc_a = rand_pc();
		drive_instr(1'b1, SYSREG_PCR, 1'b1, 1'b0, {27'd0, SYSREG_CPUIDR}, pc_a,
			UNIT_SYSREG);
		exp_fields = driven_fields();
		@(negedge iCLOCK);
		check_word(next_src0, pc_a - 32'd4, "PCR read");
		check_word(next_src1, {PROCESSOR_ID, PROCESSOR_REVISION}, "CPUIDR read");
		check_fields(exp_fields, "sysreg read");
		idle_inputs();
		drive_instr(1'b1, SYSREG_COREIDR, 1'b1, 1'b0, {27'd0, SYSREG_IDTR}, rand_pc(),
			UNIT_SYSREG);
		@(negedge iCLOCK);
		check_word(next_src0, 32'(CORE_ID_TB), "COREIDR read");
		check_word(next_src1, model_idtr, "IDTR read");

		// Interrupt entry
		idle_inputs();
		irq_set = 1'b1;
		model_ppsr = model_psr;
		model_ptidr = model_tidr;
		model_psr = model_psr & ~PSR_IRQ_BITS;
		@(negedge iCLOCK);
		check_word(sysreg_psr, model_psr, "PSR after irq_set");
		check_word(sysreg_ppsr, model_ppsr, "PPSR after irq_set");
		idle_inputs();
		drive_instr(1'b1, SYSREG_PTIDR, 1'b1, 1'b0, {27'd0, SYSREG_PSR}, rand_pc(),
			UNIT_SYSREG);
		@(negedge iCLOCK);
		check_word(next_src0, model_ptidr, "PTIDR read");
		check_word(next_src1, model_psr, "PSR read");
		idle_inputs();
		irq_clr = 1'b1;
		model_psr = model_ppsr;
		@(negedge iCLOCK);
		check_word(sysreg_psr, model_psr, "PSR after irq_clr");
		idle_inputs();
		ppcr_set = 1'b1;
		ppcr = rand_bits(WORD_W);
		model_ppcr = ppcr;
		@(negedge iCLOCK);
		check_word(sysreg_ppcr, model_ppcr, "PPCR load");

		idle_inputs();
		pc_a = rand_pc();
		drive_instr(1'b0, 5'd2, 1'b0, 1'b0, 32'd3, pc_a, UNIT_LOGIC);
		exp0 = model_gr[2];
		exp_fields = driven_fields();
		@(negedge iCLOCK);
		check_fields(exp_fields, "before lock");
		// Decoder holds the second instruction under lock
		idle_inputs();
		pc_b = rand_pc();
		drive_instr(1'b0, 5'd4, 1'b0, 1'b0, 32'd5, pc_b, UNIT_LOGIC);
		next_lock = 1'b1;
		repeat (N_LOCK_HOLD) begin
			@(negedge iCLOCK);
			check_bit(next_valid, 1'b0, "next_valid under lock");
			check_bit(previous_lock, 1'b1, "previous_lock under lock");
			check_word(next_src0, exp0, "operand 0 held under lock");
			check_fields(exp_fields, "held under lock");
		end
		next_lock = 1'b0;
		exp_fields = driven_fields();
		@(negedge iCLOCK);
		check_bit(next_valid, 1'b1, "next_valid after release");
		check_bit(previous_lock, 1'b0, "previous_lock after release");
		check_fields(exp_fields, "held instruction after release");

		idle_inputs();
		drive_instr(1'b0, 5'd1, 1'b0, 1'b0, 32'd2, rand_pc(), UNIT_BRANCH);
		@(negedge iCLOCK);
		check_bit(exception_lock, 1'b1, "exception_lock on branch");
		idle_inputs();
		drive_wb(1'b0, 5'd9, rand_bits(WORD_W), 1'b1);
		@(negedge iCLOCK);
		check_word(sysreg_pcr, model_pcr, "PCR after branch commit");
		idle_inputs();
		drive_wb(1'b0, 5'd9, rand_bits(WORD_W), 1'b0);
		@(negedge iCLOCK);
		check_word(sysreg_pcr, model_pcr, "PCR after commit");
		// Instruction offered in the refresh cycle is dropped
		idle_inputs();
		refresh = 1'b1;
		drive_instr(1'b0, 5'd6, 1'b0, 1'b0, 32'd7, rand_pc(), UNIT_LOGIC);
		@(negedge iCLOCK);
		check_bit(next_valid, 1'b0, "next_valid after refresh");
		check_bit(exception_lock, 1'b1, "exception_lock after refresh");
		check_fields('0, "after refresh");
		// No commit yet, so PCR is still invalid
		idle_inputs();
		drive_instr(1'b0, 5'd3, 1'b0, 1'b0, 32'd4, rand_pc(), UNIT_LOGIC);
		@(negedge iCLOCK);
		check_bit(exception_lock, 1'b1, "exception_lock without commit");
		idle_inputs();
		drive_instr(1'b0, 5'd3, 1'b0, 1'b0, 32'd4, rand_pc(), UNIT_LOGIC);
		drive_wb(1'b0, 5'd9, rand_bits(WORD_W), 1'b0);
		@(negedge iCLOCK);
		check_bit(exception_lock, 1'b0, "exception_lock after commit");
		idle_inputs();

		$display("TEST PASSED");
		$finish;
	end

endmodule

/* flist.f */
+incdir+dv
hw/dispatch_pkg.sv
hw/dispatch_wb_if.sv
hw/gr_file.sv
hw/sysreg_file.sv
hw/operand_select.sv
hw/dispatch_latch.sv
hw/dispatch_top.sv
dv/tb_dispatch.sv
